// ==== vlog.f ====
hw/ctrl_pkg.sv
hw/bus_pkg.sv
hw/cmd_if.sv
hw/cmd_fifo.sv
hw/cmd_parser.sv
hw/cmd_executor.sv
hw/setting_reg.sv
hw/settings_ctrl_top.sv
test/tb_clock_gen.sv
test/tb_settings_ctrl.sv

// ==== Bender.yml ====
package:
  name: settings_ctrl

sources:
  - hw/ctrl_pkg.sv
  - hw/bus_pkg.sv
  - hw/cmd_if.sv
  - hw/cmd_fifo.sv
  - hw/cmd_parser.sv
  - hw/cmd_executor.sv
  - hw/setting_reg.sv
  - hw/settings_ctrl_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_settings_ctrl.sv

// ==== test/tb_settings_ctrl.sv ====
`timescale 1ns/10ps
/* testbench for the settings controller: sends command packets and follows every ack
   line against a reference model of the register bank */
module tb_settings_ctrl;
    import ctrl_pkg::*;
    import bus_pkg::*;

    typedef struct {
        word_t  hdr;
        word_t  data;
        ticks_t ticks;
        logic   has_time;
    } cmd_t;

    localparam int N_DIRECTED     = 9;
    localparam int N_RANDOM       = 24;
    localparam int MAX_PKT_LINES  = 13;
    localparam int MAX_TS_OFFSET  = 150;
    localparam int TIMEOUT_CYCLES =
        (N_DIRECTED + N_RANDOM) * (MAX_PKT_LINES + ACK_LINES + MAX_TS_OFFSET) * 20;

    logic                 clock;
    logic                 reset;
    logic                 clear;
    ticks_t               vita_time = '0;
    line_t                in_data;
    logic                 in_valid;
    logic                 in_ready;
    line_t                out_data;
    logic                 out_valid;
    logic                 out_ready = 1'b1;
    word_t [NUM_REGS-1:0] reg_values;

    int     seed = 43;
    bit     random_mode;
    bit     hold_ready;
    int     value_errors;
    int     other_errors;
    int     sent_count;
    int     ack_count;
    int     line_no;
    int     seq_no;
    cmd_t   sent_q[$];
    cmd_t   cur;
    word_t  shadow [NUM_REGS];
    ticks_t ack_time;
    ticks_t last_ack_time;

    tb_clock_gen u_clock (.clock(clock), .reset(reset));

    settings_ctrl_top dut (
        .clock      (clock),
        .reset      (reset),
        .clear      (clear),
        .vita_time  (vita_time),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .reg_values (reg_values)
    );

    // ----------------------------
    function automatic line_t make_line(input bit sop, input bit eop, input word_t w);
        line_t l;
        l = '0;
        l[31:0] = w;
        l[LINE_SOP] = sop;
        l[LINE_EOP] = eop;
        return l;
    endfunction

    // expected ack line; the two time lines carry only their flags
    function automatic line_t expected_ack(input cmd_t c, input word_t old_value, input int idx);
        word_t w;
        w = '0;
        case (idx)
            0: begin
                w[15:0]  = ACK_BYTES;
                w[16]    = 1'b1;
                w[18:17] = PROT_DEST;
            end
            1: begin
                w[31:20] = ACK_VRT_PREFIX;
                w[19:16] = c.hdr[CMD_SEQ_HI:CMD_SEQ_LO];
                w[15:0]  = ACK_VRT_WORDS;
            end
            2: w = ACK_SID;
            5: w = c.hdr;
            6: w = old_value;
            default: w = '0;
        endcase
        return make_line(idx == 0, idx == ACK_LINES - 1, w);
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%09h expected 0x%09h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // ---------------------------- stimulus helpers
    task automatic send_line(input line_t l);
        int gap;
        @(negedge clock);
        in_data  = l;
        in_valid = 1'b1;
        do @(posedge clock); while (!in_ready);
        gap = random_mode ? $unsigned($random(seed)) % 3 : 0;
        repeat (gap) begin
            @(negedge clock);
            in_valid = 1'b0;
            @(posedge clock);
        end
    endtask

    // builds one command packet with the chosen optional fields and extra lines
    task automatic issue(input addr_t a, input bit poke, input word_t d, input bit timed,
                         input ticks_t t, input bit sid, input bit cid, input bit tsi,
                         input int extra);
        cmd_t  c;
        word_t vrt;
        c.hdr = '0;
        c.hdr[CMD_ADDR_HI:CMD_ADDR_LO] = a;
        c.hdr[CMD_POKE_BIT] = poke;
        c.hdr[CMD_SEQ_HI:CMD_SEQ_LO] = seq_no[3:0];
        c.hdr[31:24] = 8'h5c;
        c.data = d;
        c.ticks = timed ? t : '0;
        c.has_time = timed;
        seq_no++;
        vrt = 32'h0000_0005;
        vrt[HDR_SID_BIT] = sid;
        vrt[HDR_CID_BIT] = cid;
        vrt[HDR_TSI_HI:HDR_TSI_LO] = tsi ? 2'b01 : 2'b00;
        vrt[HDR_TSF_HI:HDR_TSF_LO] = timed ? 2'b01 : 2'b00;
        sent_q.push_back(c);
        sent_count++;
        send_line(make_line(1'b1, 1'b0, 32'h0000_0010));
        send_line(make_line(1'b0, 1'b0, vrt));
        if (sid) send_line(make_line(1'b0, 1'b0, 32'h0000_1234));
        if (cid) begin
            send_line(make_line(1'b0, 1'b0, 32'h00c1_0000));
            send_line(make_line(1'b0, 1'b0, 32'h00c1_0001));
        end
        if (tsi) send_line(make_line(1'b0, 1'b0, 32'h0000_0099));
        if (timed) begin
            send_line(make_line(1'b0, 1'b0, t[63:32]));
            send_line(make_line(1'b0, 1'b0, t[31:0]));
        end
        send_line(make_line(1'b0, 1'b0, c.hdr));
        send_line(make_line(1'b0, extra == 0, d));
        for (int i = 1; i <= extra; i++) begin
            send_line(make_line(1'b0, i == extra, 32'hee00_0000 + i));
        end
        @(negedge clock);
        in_valid = 1'b0;
        @(posedge clock);
    endtask

    task automatic wait_idle();
        do @(posedge clock); while (ack_count != sent_count);
    endtask

    // ---------------------------- free running time and output ready
    always @(negedge clock) begin
        vita_time <= vita_time + 1'b1;
        if (hold_ready) out_ready <= 1'b0;
        else if (random_mode) out_ready <= ($unsigned($random(seed)) % 4) != 0;
        else out_ready <= 1'b1;
    end

    // ---------------------------- compare process
    task automatic finish_ack();
        int sel;
        sel = cur.hdr[REG_SEL_BITS-1:0];
        if (cur.has_time && ack_time < cur.ticks) begin
            other_errors++;
            $display("timed command ran at time %0d, before its timestamp %0d",
                     ack_time, cur.ticks);
        end
        if (cur.hdr[CMD_POKE_BIT]) shadow[sel] = cur.data;
        for (int i = 0; i < NUM_REGS; i++) begin
            check_reg($sformatf("reg_values[%0d]", i), reg_values[i], shadow[i]);
        end
        last_ack_time = ack_time;
        ack_count <= ack_count + 1;
    endtask

    always @(posedge clock) begin
        if (!reset && out_valid && out_ready) begin
            if (line_no == 0) begin
                if (sent_q.size() == 0) begin
                    other_errors++;
                    $display("ack packet arrived with no command outstanding");
                end else begin
                    cur = sent_q.pop_front();
                end
            end
            if (line_no == 3 || line_no == 4) begin
                check_line($sformatf("out_data[35:32] line %0d", line_no),
                           {out_data[35:32], 32'd0}, expected_ack(cur, '0, line_no));
            end else begin
                check_line($sformatf("out_data line %0d", line_no), out_data,
                           expected_ack(cur, shadow[cur.hdr[REG_SEL_BITS-1:0]], line_no));
            end
            if (line_no == 3) ack_time[63:32] = out_data[31:0];
            if (line_no == 4) ack_time[31:0] = out_data[31:0];
            if (line_no == ACK_LINES - 1) begin
                finish_ack();
                line_no = 0;
            end else begin
                line_no++;
            end
        end
    end

    // ---------------------------- test sequence
    initial begin
        ticks_t t;
        ticks_t t0;
        int     ra;
        int     rd;
        int     r;
        clear       = 1'b0;
        in_data     = '0;
        in_valid    = 1'b0;
        random_mode = 1'b0;
        hold_ready  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
        @(negedge reset);
        @(posedge clock);

        // untimed poke, then peeks through aliased addresses
        issue(8'h03, 1'b1, 32'hdead_beef, 1'b0, '0, 1'b0, 1'b0, 1'b0, 0);
        wait_idle();
        issue(8'h35, 1'b1, 32'h1234_5678, 1'b0, '0, 1'b0, 1'b0, 1'b0, 0);
        issue(8'h13, 1'b0, 32'hffff_ffff, 1'b0, '0, 1'b0, 1'b0, 1'b0, 0);
        issue(8'hf5, 1'b0, 32'h0000_0000, 1'b0, '0, 1'b0, 1'b0, 1'b0, 0);
        wait_idle();

        // timed poke holds off until its time
        t = vita_time + MAX_TS_OFFSET;
        issue(8'h07, 1'b1, 32'hcafe_0007, 1'b1, t, 1'b0, 1'b0, 1'b0, 0);
        while (vita_time + 2 < t) begin
            @(posedge clock);
            check_reg("reg_values[7]", reg_values[7], shadow[7]);
        end
        wait_idle();
        t0 = vita_time;
        issue(8'h07, 1'b1, 32'h0700_0007, 1'b1, 64'd5, 1'b0, 1'b0, 1'b0, 0);
        wait_idle();
        if (last_ack_time > t0 + 40) begin
            other_errors++;
            $display("command timed in the past waited until time %0d", last_ack_time);
        end

        // optional VITA fields and trailing lines
        issue(8'h09, 1'b1, 32'h0909_a5a5, 1'b1, vita_time + 20, 1'b1, 1'b1, 1'b1, 0);
        issue(8'h09, 1'b0, 32'h0000_0000, 1'b0, '0, 1'b1, 1'b1, 1'b1, 3);
        issue(8'h29, 1'b0, 32'h0000_0000, 1'b0, '0, 1'b0, 1'b0, 1'b0, 2);
        wait_idle();

        // stalled output fills the queue and stops the parser
        hold_ready = 1'b1;
        for (int i = 0; i < CMD_DEPTH + 2; i++) begin
            issue(addr_t'(i), 1'b1, 32'hb000_0000 + i, 1'b0, '0, 1'b0, 1'b0, 1'b0, 0);
        end
        if (in_ready) begin
            other_errors++;
            $display("in_ready still high with the command queue full");
        end
        hold_ready = 1'b0;

        // random commands, gaps and output back-pressure
        random_mode = 1'b1;
        for (int i = CMD_DEPTH + 2; i < N_RANDOM; i++) begin
            ra = $random(seed);
            rd = $random(seed);
            r  = $random(seed);
            issue(addr_t'(ra), r[0], rd, r[1] & r[2], vita_time + r[13:8],
                  r[3], r[4], r[5], r[7:6]);
        end
        random_mode = 1'b0;
        wait_idle();
        repeat (20) @(posedge clock);
        if (sent_q.size() != 0 || line_no != 0) begin
            other_errors++;
            $display("commands left without a complete ack at the end of the run");
        end

        $display("commands sent %0d, acks received %0d, value errors %0d, other errors %0d",
                 sent_count, ack_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout after %0d cycles, %0d of %0d acks received",
                 TIMEOUT_CYCLES, ack_count, sent_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps
/* testbench clock and reset: 10 ns clock, reset held high for the first cycles */
module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // release on a falling edge like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== hw/settings_ctrl_top.sv ====
`timescale 1ns/10ps
/* packet controlled settings register bank: command packets in, ack packets out,
   register contents visible on reg_values */
module settings_ctrl_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   clear,
    input  ctrl_pkg::ticks_t                       vita_time,
    input  ctrl_pkg::line_t                        in_data,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    output ctrl_pkg::line_t                        out_data,
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output bus_pkg::word_t [bus_pkg::NUM_REGS-1:0] reg_values
);
    import bus_pkg::*;

    logic  set_strobe;
    addr_t set_addr;
    word_t set_data;

    cmd_if cmd_in ();
    cmd_if cmd_out ();

    // ---------------------------- command path
    cmd_parser u_parser (
        .clock    (clock),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .cmd      (cmd_in.source)
    );

    cmd_fifo u_fifo (
        .clock (clock),
        .reset (reset),
        .clear (clear),
        .push  (cmd_in.sink),
        .pop   (cmd_out.source)
    );

    cmd_executor u_executor (
        .clock      (clock),
        .reset      (reset),
        .clear      (clear),
        .vita_time  (vita_time),
        .cmd        (cmd_out.sink),
        .strobe     (set_strobe),
        .addr       (set_addr),
        .data       (set_data),
        .reg_values (reg_values),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // ---------------------------- register bank
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_regs
        setting_reg #(.INDEX(i)) u_reg (
            .clock  (clock),
            .reset  (reset),
            .strobe (set_strobe),
            .addr   (set_addr),
            .data   (set_data),
            .value  (reg_values[i])
        );
    end

endmodule

// ==== hw/setting_reg.sv ====
`timescale 1ns/10ps
/* one 32-bit setting register on the settings bus, selected by the low address bits */
module setting_reg #(
    parameter int INDEX = 0
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           strobe,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::word_t data,
    output bus_pkg::word_t value
);
    import bus_pkg::*;

    // upper address bits are ignored
    always_ff @(posedge clock) begin
        if (reset) begin
            value <= '0;
        end else if (strobe && (addr[REG_SEL_BITS-1:0] == REG_SEL_BITS'(INDEX))) begin
            value <= data;
        end
    end

endmodule

// ==== hw/cmd_executor.sv ====
`timescale 1ns/10ps
/* output side: takes one queued command, waits for its time if it has one,
   pokes or peeks the settings bus and writes a seven line ack packet */
module cmd_executor (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   clear,
    input  ctrl_pkg::ticks_t                       vita_time,
    cmd_if.sink                                    cmd,
    output logic                                   strobe,
    output bus_pkg::addr_t                         addr,
    output bus_pkg::word_t                         data,
    input  bus_pkg::word_t [bus_pkg::NUM_REGS-1:0] reg_values,
    output ctrl_pkg::line_t                        out_data,
    output logic                                   out_valid,
    input  logic                                   out_ready
);
    import ctrl_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {LOAD, WAIT_TIME, ACTION, SEND} state_t;
    typedef enum logic [2:0] {
        L_PROT, L_VRT_HDR, L_SID, L_TIME_HI, L_TIME_LO, L_CMD_HDR, L_READBACK
    } ack_line_t;

    state_t    state;
    ack_line_t line_idx;
    ticks_t    ticks_reg;
    word_t     hdr_reg;
    word_t     data_reg;
    word_t     rb_data;
    ticks_t    rb_time;
    word_t     payload;
    logic      strobe_reg;
    logic      writing;
    logic      last_line;

    assign cmd.ready = (state == LOAD);
    assign out_valid = (state == SEND);
    assign writing   = out_valid && out_ready;
    assign last_line = (line_idx == ack_line_t'(ACK_LINES - 1));

    // settings bus
    assign strobe = strobe_reg;
    assign addr   = hdr_reg[CMD_ADDR_HI:CMD_ADDR_LO];
    assign data   = data_reg;

    // ---------------------------- control
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= LOAD;
            line_idx <= L_PROT;
        end else begin
            unique case (state)
                LOAD: if (cmd.valid) state <= cmd.has_time ? WAIT_TIME : ACTION;
                WAIT_TIME: begin
                    // a late command goes straight through
                    if (clear) state <= LOAD;
                    else if (vita_time >= ticks_reg) state <= ACTION;
                end
                ACTION: begin
                    state    <= SEND;
                    line_idx <= L_PROT;
                end
                SEND: begin
                    if (writing) begin
                        if (last_line) state <= LOAD;
                        else line_idx <= ack_line_t'(line_idx + 1'b1);
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

    // one strobe cycle right after the action, pokes only
    always_ff @(posedge clock) begin
        if (reset) strobe_reg <= 1'b0;
        else strobe_reg <= (state == ACTION) && hdr_reg[CMD_POKE_BIT];
    end

    // command fields and readback snapshot
    always_ff @(posedge clock) begin
        if (cmd.valid && cmd.ready) begin
            ticks_reg <= cmd.ticks;
            hdr_reg   <= cmd.hdr;
            data_reg  <= cmd.data;
        end
        if (state == ACTION) begin
            rb_data <= reg_values[hdr_reg[REG_SEL_BITS-1:0]];
            rb_time <= vita_time;
        end
    end

    // ---------------------------- ack lines
    always_comb begin
        unique case (line_idx)
            L_PROT:     payload = {13'd0, PROT_DEST, 1'b1, ACK_BYTES};
            L_VRT_HDR:  payload = {ACK_VRT_PREFIX, hdr_reg[CMD_SEQ_HI:CMD_SEQ_LO], ACK_VRT_WORDS};
            L_SID:      payload = ACK_SID;
            L_TIME_HI:  payload = rb_time[63:32];
            L_TIME_LO:  payload = rb_time[31:0];
            L_CMD_HDR:  payload = hdr_reg;
            L_READBACK: payload = rb_data;
            default:    payload = '0;
        endcase
    end

    always_comb begin
        out_data           = '0;
        out_data[31:0]     = payload;
        out_data[LINE_SOP] = (line_idx == L_PROT);
        out_data[LINE_EOP] = last_line;
    end

endmodule

// ==== hw/cmd_parser.sv ====
`timescale 1ns/10ps
/* input side: walks one command packet line by line, keeps the fields it needs
   and offers the finished command entry to the queue */
module cmd_parser (
    input  logic            clock,
    input  logic            reset,
    input  ctrl_pkg::line_t in_data,
    input  logic            in_valid,
    output logic            in_ready,
    cmd_if.source           cmd
);
    import ctrl_pkg::*;
    import bus_pkg::*;

    typedef enum logic [3:0] {
        READ_LINE0, VITA_HDR, VITA_SID, VITA_CID0, VITA_CID1, VITA_TSI,
        VITA_TSF0, VITA_TSF1, READ_HDR, READ_DATA, WAIT_EOF, STORE
    } state_t;

    state_t state;
    logic   reading;
    logic   has_sid;
    logic   has_cid;
    logic   has_tsi;
    logic   has_tsf;
    logic   cid_reg;
    logic   tsi_reg;
    logic   tsf_reg;
    ticks_t ticks_reg;
    word_t  hdr_reg;
    word_t  data_reg;

    // first optional field still to come, else the command header
    function automatic state_t next_field(input logic sid, input logic cid,
                                          input logic tsi, input logic tsf);
        if (sid) return VITA_SID;
        if (cid) return VITA_CID0;
        if (tsi) return VITA_TSI;
        if (tsf) return VITA_TSF0;
        return READ_HDR;
    endfunction

    assign reading  = in_valid && in_ready;
    assign in_ready = (state != STORE);

    // flags as seen on the VITA header line
    assign has_sid = in_data[HDR_SID_BIT];
    assign has_cid = in_data[HDR_CID_BIT];
    assign has_tsi = |in_data[HDR_TSI_HI:HDR_TSI_LO];
    assign has_tsf = |in_data[HDR_TSF_HI:HDR_TSF_LO];

    assign cmd.valid    = (state == STORE);
    assign cmd.ticks    = ticks_reg;
    assign cmd.hdr      = hdr_reg;
    assign cmd.data     = data_reg;
    assign cmd.has_time = tsf_reg;

    // ----------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= READ_LINE0;
            cid_reg <= 1'b0;
            tsi_reg <= 1'b0;
            tsf_reg <= 1'b0;
        end else begin
            unique case (state)
                READ_LINE0: if (reading) state <= VITA_HDR;
                VITA_HDR: begin
                    if (reading) begin
                        state   <= next_field(has_sid, has_cid, has_tsi, has_tsf);
                        cid_reg <= has_cid;
                        tsi_reg <= has_tsi;
                        tsf_reg <= has_tsf;
                    end
                end
                VITA_SID: if (reading) state <= next_field(1'b0, cid_reg, tsi_reg, tsf_reg);
                VITA_CID0: if (reading) state <= VITA_CID1;
                VITA_CID1: if (reading) state <= next_field(1'b0, 1'b0, tsi_reg, tsf_reg);
                VITA_TSI: if (reading) state <= next_field(1'b0, 1'b0, 1'b0, tsf_reg);
                VITA_TSF0: if (reading) state <= VITA_TSF1;
                VITA_TSF1: if (reading) state <= READ_HDR;
                READ_HDR: if (reading) state <= READ_DATA;
                // data word may already close the packet
                READ_DATA: if (reading) state <= in_data[LINE_EOP] ? STORE : WAIT_EOF;
                WAIT_EOF: if (reading && in_data[LINE_EOP]) state <= STORE;
                STORE: if (cmd.ready) state <= READ_LINE0;
                default: state <= READ_LINE0;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clock) begin
        if (reading) begin
            if (state == VITA_TSF0) ticks_reg[63:32] <= in_data[31:0];
            if (state == VITA_TSF1) ticks_reg[31:0] <= in_data[31:0];
            if (state == READ_HDR) hdr_reg <= in_data[31:0];
            if (state == READ_DATA) data_reg <= in_data[31:0];
        end
    end

endmodule

// ==== hw/cmd_fifo.sv ====
`timescale 1ns/10ps
/* command queue between parser and executor; an entry is visible on the pop side
   the cycle after it is pushed, and clear drops everything queued */
module cmd_fifo #(
    parameter int DEPTH = bus_pkg::CMD_DEPTH
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  clear,
    cmd_if.sink   push,
    cmd_if.source pop
);
    import ctrl_pkg::*;
    import bus_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ticks_t           ticks_mem [DEPTH];
    word_t            hdr_mem   [DEPTH];
    word_t            data_mem  [DEPTH];
    logic             time_mem  [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push.ready = (count != CNT_W'(DEPTH));
    assign pop.valid  = (count != '0);
    assign do_push    = push.valid && push.ready;
    assign do_pop     = pop.valid && pop.ready;

    assign pop.ticks    = ticks_mem[rd_ptr];
    assign pop.hdr      = hdr_mem[rd_ptr];
    assign pop.data     = data_mem[rd_ptr];
    assign pop.has_time = time_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            ticks_mem[wr_ptr] <= push.ticks;
            hdr_mem[wr_ptr]   <= push.hdr;
            data_mem[wr_ptr]  <= push.data;
            time_mem[wr_ptr]  <= push.has_time;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= bump(wr_ptr);
            if (do_pop) rd_ptr <= bump(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

// ==== hw/cmd_if.sv ====
`timescale 1ns/10ps
/* one command entry with valid/ready handshake, used between parser, FIFO and executor */
interface cmd_if;

    ctrl_pkg::ticks_t ticks;
    bus_pkg::word_t   hdr;
    bus_pkg::word_t   data;
    logic             has_time;
    logic             valid;
    logic             ready;

    // source holds its fields while valid is high and ready is low
    modport source (output ticks, hdr, data, has_time, valid, input ready);
    modport sink   (input ticks, hdr, data, has_time, valid, output ready);

endinterface

// ==== hw/bus_pkg.sv ====
/* settings bus definitions: address and data widths, register count and
   the depth of the command queue in front of the bus */
package bus_pkg;

    // settings bus widths
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] word_t;

    // register bank
    localparam int NUM_REGS     = 16;

    // low address bits that pick one register
    localparam int REG_SEL_BITS = 4;

    // commands queued between parser and executor
    localparam int CMD_DEPTH    = 4;

endpackage

// ==== hw/ctrl_pkg.sv ====
/* packet level definitions shared by the command parser and the ack writer:
   stream line layout, VITA header flags, command header fields and ack constants */
package ctrl_pkg;

    // one 36-bit stream line and a VITA time
    typedef logic [35:0] line_t;
    typedef logic [63:0] ticks_t;

    // line flags
    localparam int LINE_SOP = 32;
    localparam int LINE_EOP = 33;

    // VITA header flags
    localparam int HDR_SID_BIT = 28;
    localparam int HDR_CID_BIT = 27;
    localparam int HDR_TSI_HI  = 23;
    localparam int HDR_TSI_LO  = 22;
    localparam int HDR_TSF_HI  = 21;
    localparam int HDR_TSF_LO  = 20;

    // command header fields
    localparam int CMD_ADDR_HI  = 7;
    localparam int CMD_ADDR_LO  = 0;
    localparam int CMD_POKE_BIT = 8;
    localparam int CMD_SEQ_HI   = 19;
    localparam int CMD_SEQ_LO   = 16;

    // ---------------------------- ack packet
    localparam logic [31:0] ACK_SID        = 32'h0000_00a5;
    localparam logic [1:0]  PROT_DEST      = 2'd2;
    localparam logic [15:0] ACK_BYTES      = 16'd24;
    localparam logic [11:0] ACK_VRT_PREFIX = 12'b0101_0000_0001;
    localparam logic [15:0] ACK_VRT_WORDS  = 16'd6;
    localparam int          ACK_LINES      = 7;

endpackage
